// File: filelist.f
+incdir+.
bufferSchedPkg.sv
queueBankIf.sv
keyEntry.sv
packetQueue.sv
readScheduler.sv
bufferSched.sv
tb_bufferSched.sv

// File: tb_bufferSched.sv
`default_nettype none
`timescale 1ns/1ps

`include "bufferSched_consts.svh"

module tb_bufferSched;

	logic CLOCK_50;
	logic rstN_i;
	logic btnStart_i;
	logic btn0_i;
	logic btn1_i;
	logic swa_i;
	bufferSchedPkg::regT inputReg_o;
	bufferSchedPkg::regT outputReg_o;

	// model queues, slot 0 is the oldest payload
	bufferSchedPkg::payloadT modelStore [`NUM_QUEUES][`QUEUE_DEPTH];
	int modelCnt [`NUM_QUEUES];

	logic [31:0] lfsr;
	int errCount;
	int checkCount;
	bufferSchedPkg::regT expOut;
	event readDone;

	bufferSched bufferSched_i (
		.CLOCK_50(CLOCK_50),
		.rstN_i(rstN_i),
		.btnStart_i(btnStart_i),
		.btn0_i(btn0_i),
		.btn1_i(btn1_i),
		.swa_i(swa_i),
		.inputReg_o(inputReg_o),
		.outputReg_o(outputReg_o)
	);

	// 8 ns clock
	initial begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	// galois lfsr, one step per bit taken
	function automatic logic [3:0] randBits(input int n);
		logic [3:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[2:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// push into the model, dropped when that buffer is full
	function automatic void modelPush(input int q, input bufferSchedPkg::payloadT p);
		if (modelCnt[q] < `QUEUE_DEPTH) begin
			modelStore[q][modelCnt[q]] = p;
			modelCnt[q]++;
		end
	endfunction

	// expected outputReg_o of one read, pops the winner from the model
	function automatic bufferSchedPkg::regT modelRead();
		int lat [4];
		int rel [4];
		int order [4];
		int sc [4];
		int win;
		bufferSchedPkg::regT res;
		lat = '{`LAT_W0, `LAT_W1, `LAT_W2, `LAT_W3};
		rel = '{`REL_W0, `REL_W1, `REL_W2, `REL_W3};
		// buffer 1, 4, 2, 3 on equal scores
		order = '{0, 3, 1, 2};
		for (int q = 0; q < 4; q++) begin
			if (modelCnt[q] == 0)
				sc[q] = 0;
			else if (modelCnt[q] <= `LOW_FILL)
				sc[q] = modelCnt[q] * lat[q] + rel[q];
			else
				sc[q] = modelCnt[q] * rel[q] + lat[q];
		end
		win = order[0];
		for (int k = 1; k < 4; k++) begin
			if (sc[order[k]] > sc[win])
				win = order[k];
		end
		if (modelCnt[win] == 0)
			return '0;
		res = {1'b1, 2'(win), modelStore[win][0]};
		for (int i = 1; i < `QUEUE_DEPTH; i++) begin
			modelStore[win][i-1] = modelStore[win][i];
		end
		modelCnt[win]--;
		return res;
	endfunction

	function automatic int modelTotal();
		int t;
		t = 0;
		for (int q = 0; q < `NUM_QUEUES; q++) begin
			t += modelCnt[q];
		end
		return t;
	endfunction

	// wait n edges, then step 1 ns past the last one
	task automatic stepCycle(input int n);
		repeat (n) @(posedge CLOCK_50);
		#1;
	endtask

	// comparer for every read
	always begin
		@(readDone);
		checkCount++;
		if (outputReg_o !== expOut) begin
			errCount++;
			$display("error outputReg_o got %h expected %h at %0t", outputReg_o, expOut, $time);
		end
	end

	// arm with btnStart, then press the four bits, code bit 3 first
	task automatic enterCode(input logic [3:0] code);
		int t;
		btnStart_i = 1'b0;
		stepCycle(`START_HOLD + 1);
		btnStart_i = 1'b1;
		for (int i = 3; i >= 0; i--) begin
			// btn0 enters a 1, btn1 a 0, both active low
			if (code[i])
				btn0_i = 1'b0;
			else
				btn1_i = 1'b0;
			stepCycle(2);
			btn0_i = 1'b1;
			btn1_i = 1'b1;
			stepCycle(2);
		end
		t = 0;
		while (inputReg_o !== {1'b1, code} && t < 10) begin
			stepCycle(1);
			t++;
		end
		checkCount++;
		if (inputReg_o !== {1'b1, code}) begin
			errCount++;
			$display("error inputReg_o got %h expected %h at %0t", inputReg_o, {1'b1, code},
				$time);
		end
		modelPush(code[3:2], code[1:0]);
	endtask

	// full read, swa held READ_PERIOD cycles
	task automatic timedRead();
		swa_i = 1'b1;
		stepCycle(`READ_PERIOD);
		swa_i = 1'b0;
		expOut = modelRead();
		->readDone;
		stepCycle(1);
	endtask

	// swa released one cycle early, nothing may change
	// expOut still holds the last predicted read
	task automatic shortRead();
		swa_i = 1'b1;
		stepCycle(`READ_PERIOD - 1);
		swa_i = 1'b0;
		stepCycle(2);
		->readDone;
		stepCycle(1);
	endtask

	initial begin
		int n;
		logic [3:0] pay;
		lfsr = 32'hb9cc_e250;
		errCount = 0;
		checkCount = 0;
		expOut = '0;
		for (int q = 0; q < `NUM_QUEUES; q++) begin
			modelCnt[q] = 0;
		end
		rstN_i = 1'b0;
		btnStart_i = 1'b1;
		btn0_i = 1'b1;
		btn1_i = 1'b1;
		swa_i = 1'b0;
		stepCycle(2);
		rstN_i = 1'b1;
		stepCycle(1);

		// registers clear after reset
		checkCount++;
		if (inputReg_o !== '0 || outputReg_o !== '0) begin
			errCount++;
			$display("error after reset inputReg_o %h outputReg_o %h expected 00", inputReg_o,
				outputReg_o);
		end
		// read with every buffer empty
		timedRead();

		// three payloads into buffer 2, oldest out first
		enterCode(4'b0110);
		enterCode(4'b0101);
		enterCode(4'b0111);
		repeat (3) timedRead();

		// an early switch release keeps the last read
		enterCode(4'b1100);
		enterCode(4'b1110);
		timedRead();
		shortRead();
		timedRead();

		// one packet per buffer, all score 5
		enterCode(4'b0001);
		enterCode(4'b0110);
		enterCode(4'b1011);
		enterCode(4'b1101);
		repeat (4) timedRead();

		// random fills, then drain
		repeat (12) enterCode(randBits(4));
		n = 0;
		while (modelTotal() > 0 && n < 30) begin
			timedRead();
			n++;
		end
		timedRead();

		// seven pushes into buffer 3, the last one is dropped
		repeat (7) begin
			pay = randBits(2);
			enterCode({2'b10, pay[1:0]});
		end
		repeat (7) timedRead();

		stepCycle(2);
		$display("checks %0d errors %0d", checkCount, errCount);
		if (errCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bufferSched.sv
`default_nettype none
`timescale 1ns/1ps

`include "bufferSched_consts.svh"

module bufferSched (
	input logic CLOCK_50,
	input logic rstN_i,
	input logic btnStart_i,
	input logic btn0_i,
	input logic btn1_i,
	input logic swa_i,
	output bufferSchedPkg::regT inputReg_o,
	output bufferSchedPkg::regT outputReg_o
);

	// push, pop, levels and heads of all buffers
	queueBankIf bankIf ();

	// buttons to code, push into the chosen buffer
	keyEntry keyEntry_i (
		.CLOCK_50(CLOCK_50),
		.rstN_i(rstN_i),
		.btnStart_i(btnStart_i),
		.btn0_i(btn0_i),
		.btn1_i(btn1_i),
		.bank(bankIf.entry),
		.inputReg_o(inputReg_o)
	);

	// one FIFO per buffer, each on its own slice
	for (genvar q = 0; q < `NUM_QUEUES; q++) begin : gQueue
		packetQueue #(
			.depth(`QUEUE_DEPTH)
		) packetQueue_i (
			.CLOCK_50(CLOCK_50),
			.rstN_i(rstN_i),
			.push_i(bankIf.push[q]),
			.pushData_i(bankIf.pushData),
			.pop_i(bankIf.pop[q]),
			.depth_o(bankIf.depth[q]),
			.headData_o(bankIf.headData[q])
		);
	end

	// timed read, scoring and pop
	readScheduler readScheduler_i (
		.CLOCK_50(CLOCK_50),
		.rstN_i(rstN_i),
		.swa_i(swa_i),
		.bank(bankIf.sched),
		.outputReg_o(outputReg_o)
	);

endmodule

`default_nettype wire

// File: readScheduler.sv
`default_nettype none
`timescale 1ns/1ps

`include "bufferSched_consts.svh"

module readScheduler (
	input logic CLOCK_50,
	input logic rstN_i,
	input logic swa_i,
	queueBankIf.sched bank,
	output bufferSchedPkg::regT outputReg_o
);

	// per buffer weights, buffer 1 first
	localparam int latW [4] = '{`LAT_W0, `LAT_W1, `LAT_W2, `LAT_W3};
	localparam int relW [4] = '{`REL_W0, `REL_W1, `REL_W2, `REL_W3};
	// tie order: buffer 1, 4, 2, 3
	localparam int tieOrder [4] = '{0, 3, 1, 2};

	localparam int timerW = $clog2(`READ_PERIOD + 1);

	logic [timerW-1:0] timer;
	logic readFire;

	bufferSchedPkg::scoreT score [`NUM_QUEUES];
	logic [`NUM_QUEUES-1:0] nonEmpty;
	logic anyValid;
	bufferSchedPkg::bufSelT winIdx;

	// empty scores 0
	// low fill favours latency, deeper fill favours reliability
	function automatic bufferSchedPkg::scoreT calcScore(
		input bufferSchedPkg::depthT d,
		input int latWeight,
		input int relWeight
	);
		if (d == '0) begin
			return '0;
		end else if (d <= `LOW_FILL) begin
			return bufferSchedPkg::scoreT'(d * latWeight + relWeight);
		end else begin
			return bufferSchedPkg::scoreT'(d * relWeight + latWeight);
		end
	endfunction

	// read period timer
	// fires on the cycle that makes READ_PERIOD high cycles in a row
	assign readFire = swa_i && (timer == timerW'(`READ_PERIOD - 1));

	always_ff @(posedge CLOCK_50 or negedge rstN_i) begin
		if (!rstN_i) begin
			timer <= '0;
		end else if (!swa_i || readFire) begin
			// switch low or read done, start over
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	// scores from the live fill levels
	always_comb begin
		for (int q = 0; q < `NUM_QUEUES; q++) begin
			nonEmpty[q] = (bank.depth[q] != '0);
			score[q] = calcScore(bank.depth[q], latW[q], relW[q]);
		end
	end

	assign anyValid = |nonEmpty;

	// scan in tie order, only a strictly higher score takes over
	always_comb begin
		winIdx = bufferSchedPkg::bufSelT'(tieOrder[0]);
		for (int k = 1; k < `NUM_QUEUES; k++) begin
			if (score[tieOrder[k]] > score[winIdx]) begin
				winIdx = bufferSchedPkg::bufSelT'(tieOrder[k]);
			end
		end
	end

	// pop lands on the same edge that loads the output register
	// a non-empty queue always outscores an empty one
	assign bank.pop = (readFire && anyValid) ? (`NUM_QUEUES'(1) << winIdx) : '0;

	always_ff @(posedge CLOCK_50 or negedge rstN_i) begin
		if (!rstN_i) begin
			outputReg_o <= '0;
		end else if (readFire) begin
			if (anyValid) begin
				outputReg_o <= {1'b1, winIdx, bank.headData[winIdx]};
			end else begin
				// nothing buffered, show an empty read
				outputReg_o <= '0;
			end
		end
	end

	// one queue at most, and only one that the queue bank reports as filled
	assert property (@(posedge CLOCK_50) disable iff (!rstN_i)
		(|bank.pop) |-> $onehot(bank.pop) && ((bank.pop & ~nonEmpty) == '0));

endmodule

`default_nettype wire

// File: packetQueue.sv
`default_nettype none
`timescale 1ns/1ps

`include "bufferSched_consts.svh"

module packetQueue #(
	parameter int depth = `QUEUE_DEPTH
) (
	input logic CLOCK_50,
	input logic rstN_i,
	input logic push_i,
	input bufferSchedPkg::payloadT pushData_i,
	input logic pop_i,
	output bufferSchedPkg::depthT depth_o,
	output bufferSchedPkg::payloadT headData_o
);

	// slot 0 holds the newest payload
	bufferSchedPkg::payloadT store [depth];
	// number of valid slots
	bufferSchedPkg::depthT fill;
	bufferSchedPkg::depthT headIdx;

	logic pushOk;
	logic popOk;

	// a push into a full queue is dropped
	assign pushOk = push_i && (fill != depth);
	assign popOk = pop_i && (fill != '0);

	always_ff @(posedge CLOCK_50 or negedge rstN_i) begin
		if (!rstN_i) begin
			fill <= '0;
		end else begin
			case ({pushOk, popOk})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				// push and pop together keep the level
				default: fill <= fill;
			endcase
		end
	end

	// everything moves up one slot on a push
	// the head then sits one slot higher, matching fill
	always_ff @(posedge CLOCK_50) begin
		if (pushOk) begin
			store[0] <= pushData_i;
			for (int i = 1; i < depth; i++) begin
				store[i] <= store[i-1];
			end
		end
	end

	// oldest payload sits at fill-1
	assign headIdx = fill - 1'b1;
	assign headData_o = (fill != '0) ? store[headIdx] : '0;
	assign depth_o = fill;

	// the scheduler must not pop an empty queue
	assert property (@(posedge CLOCK_50) disable iff (!rstN_i)
		pop_i |-> (fill != '0));

	// level stays within the slot count across every update
	assert property (@(posedge CLOCK_50) disable iff (!rstN_i)
		fill <= depth);

endmodule

`default_nettype wire

// File: keyEntry.sv
`default_nettype none
`timescale 1ns/1ps

`include "bufferSched_consts.svh"

module keyEntry (
	input logic CLOCK_50,
	input logic rstN_i,
	input logic btnStart_i,
	input logic btn0_i,
	input logic btn1_i,
	queueBankIf.entry bank,
	output bufferSchedPkg::regT inputReg_o
);

	bufferSchedPkg::entryStateT state;

	// start hold counter
	logic [$clog2(`START_HOLD + 1) - 1:0] holdCnt;
	// bits taken so far
	logic [1:0] bitCnt;
	// set once a bit is taken, cleared when both buttons are up
	logic pressed;
	// first three code bits, oldest on top
	logic [2:0] partial;
	bufferSchedPkg::codeT nextCode;
	logic pushStb;
	bufferSchedPkg::bufSelT pushSel;

	logic onePress;
	logic released;
	logic newBit;
	logic takeBit;

	// buttons are active low
	assign onePress = btn0_i ^ btn1_i;
	assign released = btn0_i & btn1_i;
	// btn0 gives 1, btn1 gives 0
	assign newBit = ~btn0_i;
	assign takeBit = (state == bufferSchedPkg::collecting) && !pressed && onePress;
	assign nextCode = {partial, newBit};

	always_ff @(posedge CLOCK_50 or negedge rstN_i) begin
		if (!rstN_i) begin
			state <= bufferSchedPkg::idle;
			holdCnt <= '0;
			bitCnt <= '0;
			pressed <= 1'b0;
			pushStb <= 1'b0;
			inputReg_o <= '0;
		end else begin
			pushStb <= 1'b0;
			// wait for a full release before the next bit
			if (released) begin
				pressed <= 1'b0;
			end
			case (state)
				bufferSchedPkg::idle: begin
					if (!btnStart_i) begin
						holdCnt <= 1'b1;
						state <= bufferSchedPkg::arming;
					end
				end
				bufferSchedPkg::arming: begin
					// start released too early, back to idle
					if (btnStart_i) begin
						state <= bufferSchedPkg::idle;
					end else if (holdCnt >= `START_HOLD - 1) begin
						bitCnt <= '0;
						state <= bufferSchedPkg::collecting;
					end else begin
						holdCnt <= holdCnt + 1'b1;
					end
				end
				bufferSchedPkg::collecting: begin
					if (takeBit) begin
						pressed <= 1'b1;
						bitCnt <= bitCnt + 1'b1;
						// fourth bit completes the code
						if (bitCnt == 2'd3) begin
							inputReg_o <= {1'b1, nextCode};
							pushStb <= 1'b1;
							bitCnt <= '0;
							state <= bufferSchedPkg::idle;
						end
					end
				end
				default: begin
					state <= bufferSchedPkg::idle;
				end
			endcase
		end
	end

	// code bits shift in, first bit ends up as code bit 3
	always_ff @(posedge CLOCK_50) begin
		if (takeBit) begin
			partial <= nextCode[2:0];
		end
	end

	// one-hot push into the chosen buffer for one cycle
	assign pushSel = inputReg_o[3:2];
	assign bank.push = pushStb ? (`NUM_QUEUES'(1) << pushSel) : '0;
	assign bank.pushData = inputReg_o[1:0];

	// one queue per push, and the push lasts a single cycle
	assert property (@(posedge CLOCK_50) disable iff (!rstN_i)
		(|bank.push) |-> $onehot(bank.push) ##1 !(|bank.push));

endmodule

`default_nettype wire

// File: queueBankIf.sv
`default_nettype none
`timescale 1ns/1ps

`include "bufferSched_consts.svh"

interface queueBankIf;

	// one push strobe per queue, single cycle
	logic [`NUM_QUEUES-1:0] push;
	// payload shared by all queues, only the pushed one takes it
	bufferSchedPkg::payloadT pushData;

	// one pop strobe per queue, single cycle
	logic [`NUM_QUEUES-1:0] pop;

	// live fill level of each queue
	bufferSchedPkg::depthT depth [`NUM_QUEUES];
	// oldest payload of each queue
	bufferSchedPkg::payloadT headData [`NUM_QUEUES];

	// code entry side
	modport entry (
		output push,
		output pushData
	);

	// read scheduler side
	modport sched (
		output pop,
		input depth,
		input headData
	);

	// queue side, one slice per queue
	modport bank (
		input push,
		input pushData,
		input pop,
		output depth,
		output headData
	);

endinterface

`default_nettype wire

// File: bufferSchedPkg.sv
`default_nettype none

`include "bufferSched_consts.svh"

package bufferSchedPkg;

	// buffer number, 0 is buffer 1
	typedef logic [1:0] bufSelT;

	// packet payload carried through a queue
	typedef logic [1:0] payloadT;

	// entered code, buffer index in [3:2], payload in [1:0]
	typedef logic [3:0] codeT;

	// register shown to the user
	// bit 4 valid, then the code
	typedef logic [4:0] regT;

	// fill level of one queue, 0 up to full
	typedef logic [$clog2(`QUEUE_DEPTH + 1) - 1:0] depthT;

	// scheduler score, largest is 6*4+1 = 25
	typedef logic [4:0] scoreT;

	// code entry machine
	typedef enum logic [1:0] {
		idle,
		arming,
		collecting
	} entryStateT;

endpackage

`default_nettype wire

// File: bufferSched_consts.svh
`ifndef BUFFER_SCHED_CONSTS_SVH
`define BUFFER_SCHED_CONSTS_SVH

// slots in each buffer queue
`define QUEUE_DEPTH 6

// number of buffers
`define NUM_QUEUES 4

// cycles swa must stay high before one read
// kept short for simulation, board build used 75000000
`define READ_PERIOD 16

// cycles btnStart must stay low to arm code entry
`define START_HOLD 2

// latency weights, buffer 1 first
`define LAT_W0 4
`define LAT_W1 3
`define LAT_W2 2
`define LAT_W3 1

// reliability weights, buffer 1 first
`define REL_W0 1
`define REL_W1 2
`define REL_W2 3
`define REL_W3 4

// up to this fill level latency weight dominates the score
`define LOW_FILL 3

`endif
